/* Bender.yml */
package:
  name: lenet_dot

export_include_dirs:
  - include

sources:
  - files:
      - verilog/lenet_types_pkg.sv
      - verilog/lenet_regs_pkg.sv
      - verilog/lenet_xwyf_mul.sv
      - verilog/lenet_operand_buffer.sv
      - verilog/lenet_index_counter.sv
      - verilog/lenet_mac_fsm.sv
      - verilog/lenet_accumulator.sv
      - verilog/lenet_axil_regs.sv
      - verilog/lenet_dot_top.sv
  - target: test
    files:
      - verif/lenet_dot_tb.sv

/* include/lenet_config.svh */
`ifndef LENET_CONFIG_SVH
`define LENET_CONFIG_SVH

// operand storage, one slot per vector element
`define LENET_VEC_DEPTH 16
`define LENET_IDX_W     4
`define LENET_LEN_W     5     // must hold 0 up to LENET_VEC_DEPTH

// datapath
`define LENET_ACC_W     24    // 16 products of 16 bits fit with headroom
`define LENET_SHIFT_W   4

// AXI4-Lite slave
`define LENET_ADDR_W    12
`define LENET_DATA_W    32

// operand windows, one 32-bit word per element
`define LENET_ACT_BASE  12'h100
`define LENET_WGT_BASE  12'h200

`endif

/* verif/lenet_dot_tb.sv */
`include "lenet_config.svh"

module lenet_dot_tb;

    localparam int NUM_TESTS   = 10;
    localparam int CYCLE_LIMIT = 400 * NUM_TESTS + 200;
    localparam logic [`LENET_ADDR_W-1:0] BAD_ADDR = 'h300;   // outside every window

    logic                       clk;
    logic                       reset;
    logic [`LENET_ADDR_W-1:0]   awaddr;
    logic                       awvalid;
    logic                       awready;
    logic [`LENET_DATA_W-1:0]   wdata;
    logic [`LENET_DATA_W/8-1:0] wstrb;
    logic                       wvalid;
    logic                       wready;
    logic [1:0]                 bresp;
    logic                       bvalid;
    logic                       bready;
    logic [`LENET_ADDR_W-1:0]   araddr;
    logic                       arvalid;
    logic                       arready;
    logic [`LENET_DATA_W-1:0]   rdata;
    logic [1:0]                 rresp;
    logic                       rvalid;
    logic                       rready;

    string       test_name  [NUM_TESTS];
    int unsigned test_len   [NUM_TESTS];
    int unsigned test_shift [NUM_TESTS];
    logic [7:0]  test_act   [NUM_TESTS][`LENET_VEC_DEPTH];
    logic [7:0]  test_wgt   [NUM_TESTS][`LENET_VEC_DEPTH];
    int unsigned exp_sum    [NUM_TESTS];
    int unsigned exp_out    [NUM_TESTS];
    bit          rand_ops   [NUM_TESTS];   // operands and expected values filled at run time
    bit          restart    [NUM_TESTS];   // second start written while busy

    int unsigned cycle_count;
    int unsigned checks;
    int unsigned errors;

    lenet_dot_top lenet_dot_top_inst (
        .clk, .reset,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready, .araddr, .arvalid, .arready,
        .rdata, .rresp, .rvalid, .rready
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("** Error: %s %s: expected %0d, actual %0d", name, what, expected, actual);
        end
    endtask

    task automatic aw_write(input logic [`LENET_ADDR_W-1:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
        @(posedge clk);
        awaddr  <= addr;
        awvalid <= 1'b1;
        wdata   <= data;
        wstrb   <= '1;
        wvalid  <= 1'b1;
        bready  <= 1'b1;
        do @(posedge clk); while (!(awready && wready));   // handshake on this edge
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        do @(posedge clk); while (!bvalid);
        bready  <= 1'b0;
        resp = bresp;
    endtask

    task automatic ar_read(input logic [`LENET_ADDR_W-1:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        rready  <= 1'b1;
        do @(posedge clk); while (!arready);
        arvalid <= 1'b0;
        do @(posedge clk); while (!rvalid);
        rready  <= 1'b0;
        data = rdata;
        resp = rresp;
    endtask

    task automatic write_okay(input string name, input logic [`LENET_ADDR_W-1:0] addr,
                              input logic [31:0] data);
        logic [1:0] resp;
        aw_write(addr, data, resp);
        check_value(name, "bresp", 32'(lenet_regs_pkg::RESP_OKAY), 32'(resp));
    endtask

    task automatic read_expect(input string name, input logic [`LENET_ADDR_W-1:0] addr,
                               input string what, input logic [31:0] expected);
        logic [31:0] data;
        logic [1:0]  resp;
        ar_read(addr, data, resp);
        check_value(name, what, expected, data);
        check_value(name, {what, " rresp"}, 32'(lenet_regs_pkg::RESP_OKAY), 32'(resp));
    endtask

    task automatic set_entry(input int t, input string name, input int unsigned len,
                             input int unsigned shift, input int unsigned sum,
                             input int unsigned out, input bit is_rand, input bit rs);
        test_name[t]  = name;
        test_len[t]   = len;
        test_shift[t] = shift;
        exp_sum[t]    = sum;
        exp_out[t]    = out;
        rand_ops[t]   = is_rand;
        restart[t]    = rs;
        for (int i = 0; i < `LENET_VEC_DEPTH; i++) begin
            test_act[t][i] = 8'(i * 17 + 1);   // slots past the length must not reach the sum
            test_wgt[t][i] = 8'(255 - i * 13);
        end
    endtask

    // activations are multiples of 64 so the multiplier is exact
    task automatic fill_random(input int t);
        int unsigned eff_len;
        int unsigned sum;
        int unsigned shifted;
        eff_len = (test_len[t] > `LENET_VEC_DEPTH) ? `LENET_VEC_DEPTH : test_len[t];
        sum = 0;
        for (int i = 0; i < `LENET_VEC_DEPTH; i++) begin
            test_act[t][i] = 8'(($urandom % 4) * 64);
            test_wgt[t][i] = 8'($urandom);
            if (i < eff_len) begin
                sum += test_act[t][i] * test_wgt[t][i];
            end
        end
        shifted    = sum >> test_shift[t];
        exp_sum[t] = sum;
        exp_out[t] = (shifted > 255) ? 255 : shifted;
    endtask

    task automatic build_table();
        // single products through the approximate rows, worked out by hand
        set_entry(0, "approx_lsb", 1, 1, 260, 130, 1'b0, 1'b0);
        test_act[0][0] = 8'h01;
        test_wgt[0][0] = 8'hFF;
        set_entry(1, "approx_low2", 1, 0, 416, 255, 1'b0, 1'b0);
        test_act[1][0] = 8'h03;
        test_wgt[1][0] = 8'hFF;
        set_entry(2, "approx_low6", 1, 6, 14336, 224, 1'b0, 1'b0);
        test_act[2][0] = 8'h3F;
        test_wgt[2][0] = 8'hFF;
        set_entry(3, "approx_mixed", 1, 8, 17600, 68, 1'b0, 1'b0);
        test_act[3][0] = 8'hC5;
        test_wgt[3][0] = 8'h5A;
        set_entry(4, "requant_sh0", 4, 0, 640, 255, 1'b0, 1'b0);
        set_entry(5, "requant_sh8", 4, 8, 640, 2, 1'b0, 1'b0);
        for (int i = 0; i < 4; i++) begin
            test_act[4][i] = 8'd64;
            test_wgt[4][i] = 8'(i + 1);
            test_act[5][i] = 8'd64;
            test_wgt[5][i] = 8'(i + 1);
        end
        set_entry(6, "exact_rand_a", 16, 10, 0, 0, 1'b1, 1'b0);
        set_entry(7, "exact_rand_busy", 16, 12, 0, 0, 1'b1, 1'b1);
        set_entry(8, "len_zero", 0, 0, 0, 0, 1'b0, 1'b0);
        set_entry(9, "len_clamp", 20, 9, 0, 0, 1'b1, 1'b0);
        for (int t = 0; t < NUM_TESTS; t++) begin
            if (rand_ops[t]) begin
                fill_random(t);
            end
        end
    endtask

    task automatic run_entry(input int t);
        logic [31:0] status;
        logic [1:0]  resp;
        logic [31:0] ctrl;
        ctrl = (test_shift[t] << lenet_regs_pkg::CTRL_SHIFT_LSB) |
               (32'd1 << lenet_regs_pkg::CTRL_START_BIT);
        for (int i = 0; i < `LENET_VEC_DEPTH; i++) begin
            write_okay(test_name[t], `LENET_ACT_BASE + `LENET_ADDR_W'(4 * i), 32'(test_act[t][i]));
            write_okay(test_name[t], `LENET_WGT_BASE + `LENET_ADDR_W'(4 * i), 32'(test_wgt[t][i]));
        end
        write_okay(test_name[t], lenet_regs_pkg::REG_LEN, test_len[t]);
        write_okay(test_name[t], lenet_regs_pkg::REG_CTRL, ctrl);
        if (restart[t]) begin
            read_expect(test_name[t], lenet_regs_pkg::REG_STATUS, "status while busy", 32'h1);
            write_okay(test_name[t], lenet_regs_pkg::REG_CTRL, ctrl);   // must be dropped
        end
        do begin
            ar_read(lenet_regs_pkg::REG_STATUS, status, resp);
        end while (!status[lenet_regs_pkg::STATUS_DONE_BIT]);
        check_value(test_name[t], "status at done", 32'h2, status);
        check_value(test_name[t], "status rresp", 32'(lenet_regs_pkg::RESP_OKAY), 32'(resp));
        read_expect(test_name[t], lenet_regs_pkg::REG_SUM, "sum", exp_sum[t]);
        read_expect(test_name[t], lenet_regs_pkg::REG_OUT, "out", exp_out[t]);
    endtask

    // the last table entry leaves its results behind for this one
    task automatic bus_error_check();
        logic [31:0] data;
        logic [1:0]  resp;
        aw_write(BAD_ADDR, 32'h0000_0703, resp);   // would change LEN, shift and start if decoded
        check_value("bus_error", "bresp", 32'(lenet_regs_pkg::RESP_SLVERR), 32'(resp));
        ar_read(BAD_ADDR, data, resp);
        check_value("bus_error", "rresp", 32'(lenet_regs_pkg::RESP_SLVERR), 32'(resp));
        read_expect("bus_error", lenet_regs_pkg::REG_STATUS, "status", 32'h2);
        read_expect("bus_error", lenet_regs_pkg::REG_LEN, "len", `LENET_VEC_DEPTH);
        read_expect("bus_error", lenet_regs_pkg::REG_CTRL, "ctrl",
                    test_shift[NUM_TESTS-1] << lenet_regs_pkg::CTRL_SHIFT_LSB);
        read_expect("bus_error", lenet_regs_pkg::REG_SUM, "sum", exp_sum[NUM_TESTS-1]);
        read_expect("bus_error", lenet_regs_pkg::REG_OUT, "out", exp_out[NUM_TESTS-1]);
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        awaddr      = '0;
        awvalid     = 1'b0;
        wdata       = '0;
        wstrb       = '0;
        wvalid      = 1'b0;
        bready      = 1'b0;
        araddr      = '0;
        arvalid     = 1'b0;
        rready      = 1'b0;
        cycle_count = 0;
        checks      = 0;
        errors      = 0;
        void'($urandom(32'h37ae584c));
        build_table();

        repeat (4) @(posedge clk);
        reset <= 1'b0;

        read_expect("after_reset", lenet_regs_pkg::REG_STATUS, "status", 32'h0);
        read_expect("after_reset", lenet_regs_pkg::REG_SUM, "sum", 32'h0);
        read_expect("after_reset", lenet_regs_pkg::REG_OUT, "out", 32'h0);

        for (int t = 0; t < NUM_TESTS; t++) begin
            run_entry(t);
        end
        bus_error_check();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* verilog/lenet_accumulator.sv */
`include "lenet_config.svh"

module lenet_accumulator (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      clear,
    input  logic                      en,
    input  lenet_types_pkg::product_t product,
    input  logic [`LENET_SHIFT_W-1:0] shift,
    output lenet_types_pkg::acc_t     sum,
    output lenet_types_pkg::act_t     out_act
);

    lenet_types_pkg::acc_t shifted;

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            sum <= '0;
        end else if (en) begin
            sum <= sum + lenet_types_pkg::acc_t'(product);
        end
    end

    // requantize to 8 bits
    assign shifted = sum >> shift;
    assign out_act = (shifted > lenet_types_pkg::acc_t'(8'hFF)) ? 8'hFF : shifted[7:0];

endmodule

/* verilog/lenet_axil_regs.sv */
`include "lenet_config.svh"

module lenet_axil_regs (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [`LENET_ADDR_W-1:0]     awaddr,
    input  logic                         awvalid,
    output logic                         awready,
    input  logic [`LENET_DATA_W-1:0]     wdata,
    input  logic [`LENET_DATA_W/8-1:0]   wstrb,
    input  logic                         wvalid,
    output logic                         wready,
    output logic [1:0]                   bresp,
    output logic                         bvalid,
    input  logic                         bready,
    input  logic [`LENET_ADDR_W-1:0]     araddr,
    input  logic                         arvalid,
    output logic                         arready,
    output logic [`LENET_DATA_W-1:0]     rdata,
    output logic [1:0]                   rresp,
    output logic                         rvalid,
    input  logic                         rready,
    input  logic                         busy,
    input  logic                         done,
    input  lenet_types_pkg::acc_t        sum,
    input  lenet_types_pkg::act_t        out_act,
    output logic                         start,
    output logic                         len_zero,
    output logic [`LENET_LEN_W-1:0]      len,
    output logic [`LENET_SHIFT_W-1:0]    shift,
    output logic                         act_wr_en,
    output logic                         wgt_wr_en,
    output lenet_types_pkg::idx_t        wr_idx,
    output lenet_types_pkg::act_t        wr_data
);

    localparam logic [`LENET_ADDR_W-1:0] WIN_SPAN = `LENET_ADDR_W'(`LENET_VEC_DEPTH * 4);

    logic                     wr_fire;
    logic                     rd_fire;
    logic [`LENET_DATA_W-1:0] rd_word;

    function automatic logic in_window(input logic [`LENET_ADDR_W-1:0] addr,
                                       input logic [`LENET_ADDR_W-1:0] base);
        return (addr >= base) && (addr < base + WIN_SPAN);
    endfunction

    function automatic logic in_map(input logic [`LENET_ADDR_W-1:0] addr);
        logic reg_hit;
        reg_hit = (addr == lenet_regs_pkg::REG_CTRL) || (addr == lenet_regs_pkg::REG_LEN) ||
                  (addr == lenet_regs_pkg::REG_STATUS) || (addr == lenet_regs_pkg::REG_SUM) ||
                  (addr == lenet_regs_pkg::REG_OUT);
        return reg_hit || in_window(addr, `LENET_ACT_BASE) || in_window(addr, `LENET_WGT_BASE);
    endfunction

    assign wr_fire = awvalid && awready && wvalid && wready;
    assign rd_fire = arvalid && arready;

    // operand writes go straight to the buffers on the handshake cycle
    assign act_wr_en = wr_fire && wstrb[0] && in_window(awaddr, `LENET_ACT_BASE);
    assign wgt_wr_en = wr_fire && wstrb[0] && in_window(awaddr, `LENET_WGT_BASE);
    assign wr_idx    = awaddr[2 +: `LENET_IDX_W];   // word index inside the window
    assign wr_data   = wdata[7:0];
    assign len_zero  = (len == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            bresp   <= lenet_regs_pkg::RESP_OKAY;
            start   <= 1'b0;
            len     <= '0;
            shift   <= '0;
        end else begin
            // address and data are taken together, never while a response waits
            awready <= !awready && awvalid && wvalid && !bvalid;
            wready  <= !wready && awvalid && wvalid && !bvalid;
            start   <= wr_fire && wstrb[0] && (awaddr == lenet_regs_pkg::REG_CTRL) &&
                       wdata[lenet_regs_pkg::CTRL_START_BIT] && !busy;
            if (wr_fire) begin
                bvalid <= 1'b1;
                bresp  <= in_map(awaddr) ? lenet_regs_pkg::RESP_OKAY : lenet_regs_pkg::RESP_SLVERR;
                if (awaddr == lenet_regs_pkg::REG_CTRL && wstrb[1]) begin
                    shift <= wdata[lenet_regs_pkg::CTRL_SHIFT_MSB:lenet_regs_pkg::CTRL_SHIFT_LSB];
                end
                if (awaddr == lenet_regs_pkg::REG_LEN && wstrb[0]) begin
                    len <= (wdata > `LENET_VEC_DEPTH) ? `LENET_LEN_W'(`LENET_VEC_DEPTH)
                                                      : wdata[`LENET_LEN_W-1:0];
                end
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_comb begin
        rd_word = '0;   // operand windows read back as zero
        case (araddr)
            lenet_regs_pkg::REG_CTRL:
                rd_word[lenet_regs_pkg::CTRL_SHIFT_MSB:lenet_regs_pkg::CTRL_SHIFT_LSB] = shift;
            lenet_regs_pkg::REG_LEN:    rd_word[`LENET_LEN_W-1:0] = len;
            lenet_regs_pkg::REG_STATUS: begin
                rd_word[lenet_regs_pkg::STATUS_BUSY_BIT] = busy;
                rd_word[lenet_regs_pkg::STATUS_DONE_BIT] = done;
            end
            lenet_regs_pkg::REG_SUM:    rd_word[`LENET_ACC_W-1:0] = sum;
            lenet_regs_pkg::REG_OUT:    rd_word[7:0] = out_act;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rresp   <= lenet_regs_pkg::RESP_OKAY;
            rdata   <= '0;
        end else begin
            arready <= !arready && arvalid && !rvalid;
            if (rd_fire) begin
                rvalid <= 1'b1;
                rdata  <= rd_word;
                rresp  <= in_map(araddr) ? lenet_regs_pkg::RESP_OKAY : lenet_regs_pkg::RESP_SLVERR;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // responses hold until the master takes them
    b_hold: assert property (@(posedge clk) disable iff (reset)
        bvalid && !bready |=> bvalid && $stable(bresp));
    r_hold: assert property (@(posedge clk) disable iff (reset)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

endmodule

/* verilog/lenet_dot_top.sv */
`include "lenet_config.svh"

module lenet_dot_top (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [`LENET_ADDR_W-1:0]   awaddr,
    input  logic                       awvalid,
    output logic                       awready,
    input  logic [`LENET_DATA_W-1:0]   wdata,
    input  logic [`LENET_DATA_W/8-1:0] wstrb,
    input  logic                       wvalid,
    output logic                       wready,
    output logic [1:0]                 bresp,
    output logic                       bvalid,
    input  logic                       bready,
    input  logic [`LENET_ADDR_W-1:0]   araddr,
    input  logic                       arvalid,
    output logic                       arready,
    output logic [`LENET_DATA_W-1:0]   rdata,
    output logic [1:0]                 rresp,
    output logic                       rvalid,
    input  logic                       rready
);

    logic                      start;
    logic                      len_zero;
    logic [`LENET_LEN_W-1:0]   len;
    logic [`LENET_SHIFT_W-1:0] shift;
    logic                      act_wr_en;
    logic                      wgt_wr_en;
    lenet_types_pkg::idx_t     wr_idx;
    lenet_types_pkg::act_t     wr_data;
    logic                      busy;
    logic                      done;
    logic                      cnt_clear;
    logic                      cnt_en;
    logic                      acc_clear;
    logic                      acc_en;
    lenet_types_pkg::idx_t     rd_idx;
    logic                      last;
    lenet_types_pkg::act_t     act_rd;
    lenet_types_pkg::weight_t  wgt_rd;
    lenet_types_pkg::product_t product;
    lenet_types_pkg::acc_t     sum;
    lenet_types_pkg::act_t     out_act;

    lenet_axil_regs regs_inst (
        .clk, .reset,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready, .araddr, .arvalid, .arready,
        .rdata, .rresp, .rvalid, .rready,
        .busy, .done, .sum, .out_act,
        .start, .len_zero, .len, .shift, .act_wr_en, .wgt_wr_en, .wr_idx, .wr_data
    );

    lenet_operand_buffer #(.payload_t(lenet_types_pkg::act_t)) act_buf (
        .clk, .reset, .wr_en(act_wr_en), .wr_idx, .wr_data,
        .rd_idx, .rd_data(act_rd)
    );

    lenet_operand_buffer #(.payload_t(lenet_types_pkg::weight_t)) wgt_buf (
        .clk, .reset, .wr_en(wgt_wr_en), .wr_idx, .wr_data,
        .rd_idx, .rd_data(wgt_rd)
    );

    lenet_index_counter counter_inst (
        .clk, .reset, .clear(cnt_clear), .en(cnt_en), .len, .rd_idx, .last
    );

    lenet_mac_fsm fsm_inst (
        .clk, .reset, .start, .len_zero, .last,
        .cnt_clear, .cnt_en, .acc_clear, .acc_en, .busy, .done
    );

    lenet_xwyf_mul mul_inst (
        .x(act_rd), .y(wgt_rd), .z(product)
    );

    lenet_accumulator acc_inst (
        .clk, .reset, .clear(acc_clear), .en(acc_en), .product, .shift, .sum, .out_act
    );

endmodule

/* verilog/lenet_index_counter.sv */
`include "lenet_config.svh"

module lenet_index_counter (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    clear,
    input  logic                    en,
    input  logic [`LENET_LEN_W-1:0] len,
    output lenet_types_pkg::idx_t   rd_idx,
    output logic                    last
);

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            rd_idx <= '0;
        end else if (en && !last) begin
            rd_idx <= rd_idx + 1'b1;   // parks on the last element
        end
    end

    assign last = (`LENET_LEN_W'(rd_idx) == len - 1'b1);

    // relies on the register block clamping len to the vector depth
    no_wrap: assert property (@(posedge clk) disable iff (reset || clear)
        en && !last |-> `LENET_LEN_W'(rd_idx) + 1'b1 < `LENET_LEN_W'(`LENET_VEC_DEPTH));

endmodule

/* verilog/lenet_mac_fsm.sv */
module lenet_mac_fsm (
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic len_zero,
    input  logic last,
    output logic cnt_clear,
    output logic cnt_en,
    output logic acc_clear,
    output logic acc_en,
    output logic busy,
    output logic done
);

    lenet_types_pkg::mac_state_t state;
    lenet_types_pkg::mac_state_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            lenet_types_pkg::MAC_IDLE,
            lenet_types_pkg::MAC_DONE: if (start) state_next = lenet_types_pkg::MAC_PRIME;
            lenet_types_pkg::MAC_PRIME:
                state_next = len_zero ? lenet_types_pkg::MAC_DONE : lenet_types_pkg::MAC_RUN;
            lenet_types_pkg::MAC_RUN: if (last) state_next = lenet_types_pkg::MAC_FLUSH;
            lenet_types_pkg::MAC_FLUSH: state_next = lenet_types_pkg::MAC_DONE;
            default: state_next = lenet_types_pkg::MAC_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= lenet_types_pkg::MAC_IDLE;
            acc_en <= 1'b0;
        end else begin
            state  <= state_next;
            acc_en <= cnt_en;   // data arrives one cycle after its index
        end
    end

    assign cnt_clear = (state == lenet_types_pkg::MAC_PRIME);
    assign acc_clear = (state == lenet_types_pkg::MAC_PRIME);
    assign cnt_en    = (state == lenet_types_pkg::MAC_RUN);
    assign busy      = (state == lenet_types_pkg::MAC_PRIME) ||
                       (state == lenet_types_pkg::MAC_RUN) ||
                       (state == lenet_types_pkg::MAC_FLUSH);
    assign done      = (state == lenet_types_pkg::MAC_DONE);   // held until the next start

    idle_quiet: assert property (@(posedge clk) disable iff (reset)
        state == lenet_types_pkg::MAC_IDLE |-> !acc_en);
    // the register block drops a start while busy
    no_start_in_run: assert property (@(posedge clk) disable iff (reset)
        start |-> state != lenet_types_pkg::MAC_RUN);

endmodule

/* verilog/lenet_operand_buffer.sv */
`include "lenet_config.svh"

module lenet_operand_buffer #(
    parameter type payload_t = lenet_types_pkg::act_t
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  wr_en,
    input  lenet_types_pkg::idx_t wr_idx,
    input  payload_t              wr_data,
    input  lenet_types_pkg::idx_t rd_idx,
    output payload_t              rd_data
);

    payload_t mem [`LENET_VEC_DEPTH];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `LENET_VEC_DEPTH; i++) begin
                mem[i] <= payload_t'(0);
            end
            rd_data <= payload_t'(0);
        end else begin
            if (wr_en) begin
                mem[wr_idx] <= wr_data;
            end
            rd_data <= mem[rd_idx];   // one cycle from index to data
        end
    end

endmodule

/* verilog/lenet_regs_pkg.sv */
`include "lenet_config.svh"

package lenet_regs_pkg;

    // register offsets
    localparam logic [`LENET_ADDR_W-1:0] REG_CTRL   = 'h000;
    localparam logic [`LENET_ADDR_W-1:0] REG_LEN    = 'h004;
    localparam logic [`LENET_ADDR_W-1:0] REG_STATUS = 'h008;
    localparam logic [`LENET_ADDR_W-1:0] REG_SUM    = 'h00C;
    localparam logic [`LENET_ADDR_W-1:0] REG_OUT    = 'h010;

    // CTRL fields
    localparam int unsigned CTRL_START_BIT = 0;     // write one, self clearing
    localparam int unsigned CTRL_SHIFT_LSB = 8;
    localparam int unsigned CTRL_SHIFT_MSB = 11;

    // STATUS fields
    localparam int unsigned STATUS_BUSY_BIT = 0;
    localparam int unsigned STATUS_DONE_BIT = 1;

    // AXI response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

/* verilog/lenet_types_pkg.sv */
`include "lenet_config.svh"

package lenet_types_pkg;

    typedef logic [7:0] act_t;                  // unsigned activation
    typedef logic [7:0] weight_t;               // unsigned weight
    typedef logic [15:0] product_t;             // full 8x8 product width
    typedef logic [`LENET_ACC_W-1:0] acc_t;
    typedef logic [`LENET_IDX_W-1:0] idx_t;

    // one run: clear in prime, stream in run, drain the read pipe in flush
    typedef enum logic [2:0] {
        MAC_IDLE,
        MAC_PRIME,
        MAC_RUN,
        MAC_FLUSH,
        MAC_DONE
    } mac_state_t;

endpackage

/* verilog/lenet_xwyf_mul.sv */
module lenet_xwyf_mul (
    input  lenet_types_pkg::act_t     x,
    input  lenet_types_pkg::weight_t  y,
    output lenet_types_pkg::product_t z
);

    logic [7:0]  pp [8];    // pp[i] is y gated by x[i]
    logic [12:0] row1;
    logic [12:0] row2;
    logic [12:0] row3;
    logic [12:0] row4;
    logic [12:0] row5;
    logic [12:0] row6;

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            pp[i] = y & {8{x[i]}};
        end
    end

    // low six rows collapse into gate terms, carries between them are dropped
    always_comb begin
        row1 = '0;
        row2 = '0;
        row3 = '0;
        row4 = '0;
        row5 = '0;
        row6 = '0;

        row1[2]  = pp[0][2] ^ pp[1][1];
        row1[5]  = pp[0][5] & pp[1][4];
        row1[6]  = pp[2][4] | pp[3][3];
        row1[7]  = pp[0][6] & pp[1][5];
        row1[8]  = pp[0][7] ^ pp[1][6];
        row1[9]  = pp[2][7] | pp[3][6];
        row1[10] = pp[3][7];
        row1[11] = pp[4][7] ^ pp[5][6];
        row1[12] = pp[4][7] & pp[5][6];

        row2[5]  = pp[4][1] | pp[5][0];
        row2[6]  = pp[4][1] ^ pp[5][0];
        row2[8]  = pp[1][7];
        row2[9]  = pp[4][4] & pp[5][3];
        row2[10] = pp[4][5] & pp[5][4];
        row2[12] = pp[5][7];

        row3[8]  = pp[2][5] | pp[3][4];
        row3[9]  = pp[4][5] ^ pp[5][4];
        row3[10] = pp[4][6] & pp[5][5];

        row4[8]  = pp[2][6] ^ pp[3][5];
        row4[10] = pp[4][6] | pp[5][5];

        row5[8]  = pp[4][3] | pp[5][2];

        row6[8]  = pp[4][4] ^ pp[5][3];
    end

    // top two rows stay exact
    assign z = lenet_types_pkg::product_t'({pp[6], 6'b0}) +
               lenet_types_pkg::product_t'({pp[7], 7'b0}) +
               row1 + row2 + row3 + row4 + row5 + row6;

endmodule

/* vlog.f */
+incdir+include
verilog/lenet_types_pkg.sv
verilog/lenet_regs_pkg.sv
verilog/lenet_xwyf_mul.sv
verilog/lenet_operand_buffer.sv
verilog/lenet_index_counter.sv
verilog/lenet_mac_fsm.sv
verilog/lenet_accumulator.sv
verilog/lenet_axil_regs.sv
verilog/lenet_dot_top.sv
verif/lenet_dot_tb.sv
